// ==== files.f ====
hw/pdp8Pkg.sv
hw/sequencer.sv
hw/instrDecode.sv
hw/execUnit.sv
hw/coreMemory.sv
hw/pdp8Core.sv
tb/clockGen.sv
tb/pdp8Tb.sv

// ==== hw/coreMemory.sv ====
`default_nettype none

module coreMemory (
  input  logic               CLK,
  input  pdp8Pkg::memReq_t   memReq,
  input  pdp8Pkg::loadReq_t  load,
  input  logic               loadValid,
  output pdp8Pkg::word_t     rdData
);

  pdp8Pkg::word_t mem [pdp8Pkg::MemWords];

  always_ff @(posedge CLK) begin
    if (loadValid) begin
      mem[load.addr] <= load.data;  // Load port wins
    end else if (memReq.wr) begin
      mem[memReq.addr] <= memReq.wrData;
    end
    rdData <= mem[memReq.addr];  // Valid during the strobe cycle
  end

  // Loads only happen while the core is stopped
  assert property (@(posedge CLK) loadValid |-> !memReq.wr);

endmodule

`default_nettype wire

// ==== hw/execUnit.sv ====
`default_nettype none

module execUnit (
  input  logic                CLK,
  input  logic                RESET,
  input  logic                run,
  input  pdp8Pkg::addr_t      startPc,
  input  logic                running,
  input  pdp8Pkg::phases_t    phases,
  input  pdp8Pkg::decoded_t   dec,
  input  pdp8Pkg::word_t      rdData,
  output pdp8Pkg::word_t      ir,
  output pdp8Pkg::memReq_t    memReq,
  output logic                done,
  output logic                haltReq,
  output pdp8Pkg::retire_t    retire,
  output logic                retireValid
);

  pdp8Pkg::word_t acReg;
  pdp8Pkg::word_t acNext;
  pdp8Pkg::word_t mbReg;
  pdp8Pkg::word_t mbNext;
  pdp8Pkg::word_t irReg;
  pdp8Pkg::addr_t pcReg;
  pdp8Pkg::addr_t pcNext;
  pdp8Pkg::addr_t eaReg;
  pdp8Pkg::addr_t eaNext;
  pdp8Pkg::addr_t instPc;
  logic           linkReg;
  logic           linkNext;
  logic [12:0]    tadSum;
  logic [12:0]    incSum;
  logic           isMemRef;

  assign isMemRef = dec.opcode != pdp8Pkg::OpIot && dec.opcode != pdp8Pkg::OpOpr;
  assign tadSum   = {1'b0, acReg} + {1'b0, mbReg};
  assign incSum   = {linkReg, acReg} + 13'd1;

  // Sequencer decodes the fetched word while it is still on the read bus
  assign ir = phases.stb[pdp8Pkg::PhFetch] ? rdData : irReg;

  always_comb begin
    memReq.addr   = pcReg;
    memReq.wrData = acReg;
    memReq.wr     = 1'b0;
    if (phases.ck[pdp8Pkg::PhAuto1] || phases.ck[pdp8Pkg::PhInd]) begin
      memReq.addr = eaReg;
    end
    if (phases.ck[pdp8Pkg::PhAuto2]) begin
      memReq.addr   = eaReg;
      memReq.wrData = mbReg + 12'd1;  // Pointer plus one
      memReq.wr     = phases.stb[pdp8Pkg::PhAuto2];
    end
    if (phases.ck[pdp8Pkg::PhE1] && isMemRef && dec.opcode != pdp8Pkg::OpJmp) begin
      memReq.addr = eaReg;
      if (dec.opcode == pdp8Pkg::OpDca) begin
        memReq.wr = phases.stb[pdp8Pkg::PhE1];
      end
      if (dec.opcode == pdp8Pkg::OpJms) begin
        memReq.wrData = pcReg;  // Return address
        memReq.wr     = phases.stb[pdp8Pkg::PhE1];
      end
    end
    if (phases.ck[pdp8Pkg::PhE3] && dec.opcode == pdp8Pkg::OpIsz) begin
      memReq.addr   = eaReg;
      memReq.wrData = mbReg;
      memReq.wr     = phases.stb[pdp8Pkg::PhE3];
    end
  end

  always_comb begin
    acNext   = acReg;
    linkNext = linkReg;
    pcNext   = pcReg;
    mbNext   = mbReg;
    eaNext   = eaReg;
    done     = 1'b0;
    haltReq  = 1'b0;

    if (run && !running) pcNext = startPc;

    if (phases.stb[pdp8Pkg::PhFetch]) begin
      pcNext = pcReg + 12'd1;
      eaNext = {dec.curPage ? pcReg[11:7] : 5'b0, dec.offset};  // Page of the instruction
    end
    if (phases.stb[pdp8Pkg::PhAuto1]) mbNext = rdData;
    if (phases.stb[pdp8Pkg::PhAuto2]) mbNext = mbReg + 12'd1;
    if (phases.stb[pdp8Pkg::PhInd]) begin
      eaNext = (dec.seqType == pdp8Pkg::SeqAuto) ? mbReg : rdData;
    end

    if (phases.stb[pdp8Pkg::PhE1]) begin
      case (dec.opcode)
        pdp8Pkg::OpAnd, pdp8Pkg::OpTad, pdp8Pkg::OpIsz: mbNext = rdData;
        pdp8Pkg::OpDca: begin
          acNext = '0;
          done   = 1'b1;
        end
        pdp8Pkg::OpJmp: begin
          pcNext = eaReg;
          done   = 1'b1;
        end
        pdp8Pkg::OpJms: begin
          pcNext = eaReg + 12'd1;
          done   = 1'b1;
        end
        pdp8Pkg::OpIot: done = 1'b1;  // Not implemented, retires as a no-op
        default: begin
          if (dec.cla) acNext = '0;
          if (dec.cll) linkNext = 1'b0;
          done    = dec.hlt;
          haltReq = dec.hlt;
        end
      endcase
    end

    if (phases.stb[pdp8Pkg::PhE2]) begin
      case (dec.opcode)
        pdp8Pkg::OpAnd: begin
          acNext = acReg & mbReg;
          done   = 1'b1;
        end
        pdp8Pkg::OpTad: begin
          acNext   = tadSum[11:0];
          linkNext = linkReg ^ tadSum[12];  // Carry flips the link
          done     = 1'b1;
        end
        pdp8Pkg::OpIsz: mbNext = mbReg + 12'd1;
        pdp8Pkg::OpOpr: begin
          if (dec.cma) acNext = ~acReg;
          if (dec.cml) linkNext = ~linkReg;
        end
        default: ;
      endcase
    end

    if (phases.stb[pdp8Pkg::PhE3]) begin
      if (dec.opcode == pdp8Pkg::OpIsz) begin
        if (mbReg == '0) pcNext = pcReg + 12'd1;  // Skip
        done = 1'b1;
      end
      if (dec.opcode == pdp8Pkg::OpOpr && dec.iac) {linkNext, acNext} = incSum;
    end

    if (phases.stb[pdp8Pkg::PhE4]) begin
      if (dec.rar) begin
        linkNext = acReg[0];
        acNext   = {linkReg, acReg[11:1]};
      end
      if (dec.ral) begin
        linkNext = acReg[11];
        acNext   = {acReg[10:0], linkReg};
      end
      done = 1'b1;  // Only operate instructions reach E4
    end
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      acReg   <= '0;
      linkReg <= 1'b0;
      pcReg   <= '0;
    end else begin
      acReg   <= acNext;
      linkReg <= linkNext;
      pcReg   <= pcNext;
    end
  end

  always_ff @(posedge CLK) begin
    mbReg <= mbNext;
    eaReg <= eaNext;
    if (phases.stb[pdp8Pkg::PhFetch]) begin
      irReg  <= rdData;
      instPc <= pcReg;
    end
  end

  // Record carries the state the registers take at this edge
  assign retire      = '{pc: instPc, ac: acNext, link: linkNext, nextPc: pcNext};
  assign retireValid = done;

  // Write lands on the strobe after the address was held through the clock cycle
  assert property (@(posedge CLK) disable iff (RESET)
    memReq.wr |-> (|phases.stb) && memReq.addr == $past(memReq.addr));

  // Retire strobe never lasts two cycles
  assert property (@(posedge CLK) disable iff (RESET)
    retireValid |=> !retireValid);

endmodule

`default_nettype wire

// ==== hw/instrDecode.sv ====
`default_nettype none

module instrDecode (
  input  pdp8Pkg::word_t    ir,
  output pdp8Pkg::decoded_t dec
);

  logic isOpr;
  logic group1;
  logic group2;
  logic memRef;
  logic autoRange;

  assign isOpr  = ir[11:9] == 3'b111;
  assign group1 = isOpr && !ir[8];
  assign group2 = isOpr && ir[8] && !ir[0];
  assign memRef = ir[11:9] < 3'd6;  // AND through JMP

  // Page zero and inside 0010..0017
  assign autoRange = !ir[7] &&
                     (pdp8Pkg::addr_t'(ir[6:0]) >= pdp8Pkg::AutoLo) &&
                     (pdp8Pkg::addr_t'(ir[6:0]) <= pdp8Pkg::AutoHi);

  always_comb begin
    dec.opcode   = pdp8Pkg::opcode_e'(ir[11:9]);
    dec.indirect = ir[8];
    dec.curPage  = ir[7];
    dec.offset   = ir[6:0];

    if (memRef && ir[8]) begin
      dec.seqType = autoRange ? pdp8Pkg::SeqAuto : pdp8Pkg::SeqInd;
    end else begin
      dec.seqType = pdp8Pkg::SeqDirect;
    end

    // Operate microcode bits
    dec.cla = isOpr && ir[7];
    dec.cll = group1 && ir[6];
    dec.cma = group1 && ir[5];
    dec.cml = group1 && ir[4];
    dec.rar = group1 && ir[3];
    dec.ral = group1 && ir[2];
    dec.iac = group1 && ir[0];
    dec.hlt = group2 && ir[1];
  end

endmodule

`default_nettype wire

// ==== hw/pdp8Core.sv ====
`default_nettype none

module pdp8Core (
  input  logic               CLK,
  input  logic               RESET,
  input  pdp8Pkg::loadReq_t  load,
  input  logic               loadValid,
  input  logic               run,
  input  pdp8Pkg::addr_t     startPc,
  output pdp8Pkg::retire_t   retire,
  output logic               retireValid,
  output logic               halted
);

  pdp8Pkg::phases_t  phases;
  pdp8Pkg::decoded_t dec;
  pdp8Pkg::word_t    ir;
  pdp8Pkg::word_t    rdData;
  pdp8Pkg::memReq_t  memReq;
  logic              running;
  logic              done;
  logic              haltReq;

  sequencer sequencer_i (
    .CLK     (CLK),
    .RESET   (RESET),
    .run     (run),
    .done    (done),
    .haltReq (haltReq),
    .seqType (dec.seqType),
    .phases  (phases),
    .running (running)
  );

  instrDecode instrDecode_i (
    .ir  (ir),
    .dec (dec)
  );

  execUnit execUnit_i (
    .CLK         (CLK),
    .RESET       (RESET),
    .run         (run),
    .startPc     (startPc),
    .running     (running),
    .phases      (phases),
    .dec         (dec),
    .rdData      (rdData),
    .ir          (ir),
    .memReq      (memReq),
    .done        (done),
    .haltReq     (haltReq),
    .retire      (retire),
    .retireValid (retireValid)
  );

  coreMemory coreMemory_i (
    .CLK       (CLK),
    .memReq    (memReq),
    .load      (load),
    .loadValid (loadValid),
    .rdData    (rdData)
  );

  assign halted = !running;

endmodule

`default_nettype wire

// ==== hw/pdp8Pkg.sv ====
`default_nettype none

package pdp8Pkg;

  localparam int WordBits  = 12;
  localparam int AddrBits  = 12;
  localparam int MemWords  = 1 << AddrBits;
  localparam int NumPhases = 10;

  typedef logic [WordBits-1:0]  word_t;
  typedef logic [AddrBits-1:0]  addr_t;
  typedef logic [4:0]           stepCnt_t;
  typedef logic [6:0]           offset_t;   // Page offset field of a memory reference
  typedef logic [NumPhases-1:0] phaseVec_t;

  // Auto-index locations on page zero
  localparam addr_t AutoLo = 12'o0010;
  localparam addr_t AutoHi = 12'o0017;

  localparam stepCnt_t LastStep = 5'd19;

  // Bit positions inside the phase vectors
  localparam int PhFetch = 0;
  localparam int PhAuto1 = 1;
  localparam int PhAuto2 = 2;
  localparam int PhInd   = 3;
  localparam int PhE1    = 4;
  localparam int PhE2    = 5;
  localparam int PhE3    = 6;
  localparam int PhE4    = 7;

  localparam stepCnt_t StepExec1 = stepCnt_t'(2 * PhE1);  // First step of E1

  typedef enum logic [2:0] {
    OpAnd, OpTad, OpIsz, OpDca, OpJms, OpJmp, OpIot, OpOpr
  } opcode_e;

  // Value times two is the distance skipped back from E1 at step 1
  typedef enum logic [1:0] {
    SeqDirect = 2'd0,
    SeqInd    = 2'd1,
    SeqAuto   = 2'd3
  } seqType_e;

  typedef struct packed {
    phaseVec_t ck;   // Both cycles of a phase
    phaseVec_t stb;  // Second cycle only
  } phases_t;

  typedef struct packed {
    opcode_e  opcode;
    logic     indirect;
    logic     curPage;
    offset_t  offset;
    seqType_e seqType;
    logic     cla;
    logic     cll;
    logic     cma;
    logic     cml;
    logic     iac;
    logic     rar;
    logic     ral;
    logic     hlt;
  } decoded_t;

  typedef struct packed {
    addr_t addr;
    word_t wrData;
    logic  wr;
  } memReq_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
  } loadReq_t;

  typedef struct packed {
    addr_t pc;      // Address of the finished instruction
    word_t ac;
    logic  link;
    addr_t nextPc;
  } retire_t;

endpackage

`default_nettype wire

// ==== hw/sequencer.sv ====
`default_nettype none

module sequencer (
  input  logic              CLK,
  input  logic              RESET,
  input  logic              run,
  input  logic              done,
  input  logic              haltReq,
  input  pdp8Pkg::seqType_e seqType,
  output pdp8Pkg::phases_t  phases,
  output logic              running
);

  pdp8Pkg::stepCnt_t  stepCnt;
  pdp8Pkg::phaseVec_t phaseSel;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      running <= 1'b0;
      stepCnt <= '0;
    end else if (!running) begin
      running <= run;  // First fetch follows on the next cycle
      stepCnt <= '0;
    end else if (done) begin
      running <= !haltReq;
      stepCnt <= '0;
    end else if (stepCnt == 5'd1) begin
      // Skip the address phases the instruction does not need
      stepCnt <= pdp8Pkg::StepExec1 - pdp8Pkg::stepCnt_t'({seqType, 1'b0});
    end else begin
      stepCnt <= stepCnt + 5'd1;
    end
  end

  // Two steps per phase, odd step is the strobe
  assign phaseSel   = running ? pdp8Pkg::phaseVec_t'(1) << stepCnt[4:1] : '0;
  assign phases.ck  = phaseSel;
  assign phases.stb = stepCnt[0] ? phaseSel : '0;

  assert property (@(posedge CLK) disable iff (RESET)
    stepCnt <= pdp8Pkg::LastStep);

  assert property (@(posedge CLK) disable iff (RESET)
    $onehot0(phases.stb));

  // Execute unit may only finish on a strobe
  assert property (@(posedge CLK) disable iff (RESET)
    done |-> |phases.stb);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the PDP-8 core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module pdp8Tb -f files.f

./obj_dir/Vpdp8Tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
exit 0

// ==== tb/clockGen.sv ====
`default_nettype none

module clockGen (
  output logic CLK,
  output logic RESET
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;  // 100 ns period
  end

  initial begin
    RESET = 1'b1;
    repeat (16) @(posedge CLK);
    @(negedge CLK);
    RESET = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/pdp8Tb.sv ====
`default_nettype none

module pdp8Tb;

  timeunit 1ns;
  timeprecision 1ps;

  // About 110 instructions, 300 load cycles and the reset
  localparam int InstrBudget = 120;
  localparam int CycleLimit  = InstrBudget * 20 + 320 + 500;

  logic              CLK;
  logic              RESET;
  pdp8Pkg::loadReq_t load;
  logic              loadValid;
  logic              run;
  pdp8Pkg::addr_t    startPc;
  pdp8Pkg::retire_t  retire;
  logic              retireValid;
  logic              halted;

  pdp8Pkg::word_t refMem [4096];
  pdp8Pkg::word_t refAc;
  logic           refLink;
  pdp8Pkg::addr_t refPc;
  logic           refHalted;
  logic           expectStop;
  int             errorCount;
  int             passCount;
  int             failCount;
  int             cycleCount;

  clockGen clockGen_i (.CLK(CLK), .RESET(RESET));

  pdp8Core pdp8Core_i (
    .CLK(CLK), .RESET(RESET), .load(load), .loadValid(loadValid), .run(run),
    .startPc(startPc), .retire(retire), .retireValid(retireValid), .halted(halted)
  );

  // Instruction-set model, one instruction per call
  function automatic pdp8Pkg::retire_t stepModel();
    pdp8Pkg::word_t   inst;
    pdp8Pkg::addr_t   ea;
    logic [12:0]      sum;
    pdp8Pkg::retire_t r;
    inst  = refMem[refPc];
    r.pc  = refPc;
    refPc = refPc + 12'd1;
    ea    = {inst[7] ? r.pc[11:7] : 5'b0, inst[6:0]};
    if (inst[11:9] < 3'd6 && inst[8]) begin
      if (ea >= 12'o0010 && ea <= 12'o0017) refMem[ea] = refMem[ea] + 12'd1;  // Pre-increment
      ea = refMem[ea];
    end
    case (inst[11:9])
      3'd0: refAc = refAc & refMem[ea];
      3'd1: begin
        sum     = {1'b0, refAc} + {1'b0, refMem[ea]};
        refAc   = sum[11:0];
        refLink = refLink ^ sum[12];
      end
      3'd2: begin
        refMem[ea] = refMem[ea] + 12'd1;
        if (refMem[ea] == 12'd0) refPc = refPc + 12'd1;
      end
      3'd3: begin
        refMem[ea] = refAc;
        refAc      = 12'd0;
      end
      3'd4: begin
        refMem[ea] = refPc;
        refPc      = ea + 12'd1;
      end
      3'd5: refPc = ea;
      3'd6: ;
      default: begin
        if (inst[7]) refAc = 12'd0;
        if (!inst[8]) begin
          if (inst[6]) refLink = 1'b0;
          if (inst[5]) refAc = ~refAc;
          if (inst[4]) refLink = ~refLink;
          if (inst[0]) {refLink, refAc} = {refLink, refAc} + 13'd1;
          if (inst[2]) {refLink, refAc} = {refAc, refLink};
          else if (inst[3]) {refAc, refLink} = {refLink, refAc};
        end else if (inst[1]) begin
          refHalted = 1'b1;
        end
      end
    endcase
    r.ac     = refAc;
    r.link   = refLink;
    r.nextPc = refPc;
    return r;
  endfunction

  task automatic checkRetire(input pdp8Pkg::retire_t exp, input pdp8Pkg::retire_t got);
    if (got.pc !== exp.pc) begin
      $display("** Error at %0t ns: retire.pc expected %o, got %o", $time, exp.pc, got.pc);
      errorCount++;
    end
    if (got.ac !== exp.ac) begin
      $display("** Error at %0t ns: retire.ac expected %o, got %o", $time, exp.ac, got.ac);
      errorCount++;
    end
    if (got.link !== exp.link) begin
      $display("** Error at %0t ns: retire.link expected %b, got %b", $time, exp.link, got.link);
      errorCount++;
    end
    if (got.nextPc !== exp.nextPc) begin
      $display("** Error at %0t ns: retire.nextPc expected %o, got %o",
               $time, exp.nextPc, got.nextPc);
      errorCount++;
    end
  endtask

  task automatic checkHalted(input logic expHalt, input logic isHalted);
    if (expHalt && !isHalted) begin
      $display("At %0t ns the core kept running after HLT", $time);
      errorCount++;
    end else if (!expHalt && isHalted) begin
      $display("At %0t ns the core stopped without executing HLT", $time);
      errorCount++;
    end
  endtask

  // Compare process
  always @(posedge CLK) begin
    if (!RESET) begin
      if (expectStop) begin
        checkHalted(1'b1, halted);
        expectStop <= 1'b0;
      end
      if (retireValid) begin
        if (refHalted) begin
          checkHalted(1'b1, 1'b0);  // Retire after the model halted
        end else begin
          checkRetire(stepModel(), retire);
          if (refHalted) expectStop <= 1'b1;
        end
      end
    end
  end

  always @(posedge CLK) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) begin
      $display("Timeout after %0d cycles, the core did not reach HLT", cycleCount);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic loadWord(input pdp8Pkg::addr_t a, input pdp8Pkg::word_t d);
    load      = '{addr: a, data: d};
    loadValid = 1'b1;
    refMem[a] = d;
    @(negedge CLK);
    loadValid = 1'b0;
  endtask

  task automatic runFrom(input pdp8Pkg::addr_t pc);
    startPc   = pc;
    run       = 1'b1;
    refPc     = pc;
    refHalted = 1'b0;
    @(negedge CLK);
    run = 1'b0;
    while (!halted) @(negedge CLK);
    checkHalted(refHalted, 1'b1);
  endtask

  task automatic endTest(input string name, input int errsBefore);
    if (errorCount == errsBefore) begin
      passCount++;
      $display("Test %s passed", name);
    end else begin
      failCount++;
      $display("Test %s failed with %0d errors", name, errorCount - errsBefore);
    end
  endtask

  task automatic directTest();
    logic [31:0]    rnd;
    pdp8Pkg::word_t inst;
    int             errs;
    errs = errorCount;
    for (int round = 0; round < 3; round++) begin
      for (int i = 0; i < 32; i++) begin
        loadWord(12'o0040 + 12'(i), pdp8Pkg::word_t'($urandom));
        loadWord(12'o0300 + 12'(i), pdp8Pkg::word_t'($urandom));
      end
      for (int i = 0; i < 20; i++) begin
        rnd  = $urandom;
        inst = rnd[1:0] == 2'd0 ? 12'o0000 : (rnd[1:0] == 2'd3 ? 12'o3000 : 12'o1000);
        if (rnd[2]) inst = inst | 12'o0300 | {7'b0, rnd[7:3]};  // Current page, 0300 up
        else inst = inst | 12'o0040 | {7'b0, rnd[7:3]};
        loadWord(12'o0200 + 12'(i), inst);
      end
      loadWord(12'o0224, 12'o7402);
      runFrom(12'o0200);
    end
    endTest("direct", errs);
  endtask

  task automatic indirectTest();
    int errs;
    errs = errorCount;
    loadWord(12'o0030, 12'o0500);
    loadWord(12'o0031, 12'o0600);
    loadWord(12'o0500, 12'o1234);
    loadWord(12'o0600, 12'o7402);
    loadWord(12'o0400, 12'o1430);  // TAD I 0030
    loadWord(12'o0401, 12'o5431);  // JMP I 0031
    loadWord(12'o0402, 12'o7402);
    runFrom(12'o0400);
    endTest("indirect", errs);
  endtask

  task automatic autoIndexTest();
    int errs;
    errs = errorCount;
    loadWord(12'o0010, 12'o0677);
    loadWord(12'o0700, 12'o0111);
    loadWord(12'o0701, 12'o0222);
    loadWord(12'o1000, 12'o7200);
    loadWord(12'o1001, 12'o1410);  // TAD I 0010 twice
    loadWord(12'o1002, 12'o1410);
    loadWord(12'o1003, 12'o7200);
    loadWord(12'o1004, 12'o1010);  // Pointer itself
    loadWord(12'o1005, 12'o7402);
    runFrom(12'o1000);
    endTest("auto-index", errs);
  endtask

  task automatic operateTest();
    logic [31:0]    rnd;
    pdp8Pkg::word_t inst;
    int             errs;
    errs = errorCount;
    for (int i = 0; i < 20; i++) begin
      rnd  = $urandom;
      inst = 12'o7000 | {4'b0, rnd[0], rnd[1], rnd[2], rnd[3], 3'b0, rnd[4]};
      if (rnd[6:5] == 2'd1) inst = inst | 12'o0010;
      if (rnd[6:5] == 2'd2) inst = inst | 12'o0004;
      loadWord(12'o1200 + 12'(i), inst);
    end
    loadWord(12'o1224, 12'o7402);
    runFrom(12'o1200);
    endTest("operate", errs);
  endtask

  task automatic controlTest();
    int errs;
    errs = errorCount;
    loadWord(12'o1400, 12'o4220);  // JMS 1420
    loadWord(12'o1401, 12'o7200);
    loadWord(12'o1402, 12'o1220);  // Return address back into AC
    loadWord(12'o1403, 12'o7402);
    loadWord(12'o1420, 12'o0000);
    loadWord(12'o1421, 12'o2230);  // ISZ 1430 skips
    loadWord(12'o1422, 12'o7402);
    loadWord(12'o1423, 12'o2231);  // ISZ 1431 does not
    loadWord(12'o1424, 12'o5620);
    loadWord(12'o1430, 12'o7777);
    loadWord(12'o1431, 12'o0005);
    runFrom(12'o1400);
    endTest("control", errs);
  endtask

  task automatic haltTest();
    int errs;
    errs = errorCount;
    loadWord(12'o1600, 12'o7402);
    loadWord(12'o1601, 12'o7001);
    loadWord(12'o1602, 12'o7402);
    runFrom(12'o1600);
    repeat (20) @(negedge CLK);
    checkHalted(1'b1, halted);
    runFrom(12'o1601);
    endTest("halt", errs);
  endtask

  initial begin
    void'($urandom(32'h4828));
    load       = '0;
    loadValid  = 1'b0;
    run        = 1'b0;
    startPc    = '0;
    refAc      = '0;
    refLink    = 1'b0;
    refPc      = '0;
    refHalted  = 1'b1;
    expectStop = 1'b0;
    errorCount = 0;
    passCount  = 0;
    failCount  = 0;
    cycleCount = 0;
    @(negedge RESET);
    @(negedge CLK);
    directTest();
    indirectTest();
    autoIndexTest();
    operateTest();
    controlTest();
    haltTest();
    $display("Tests passed: %0d, failed: %0d, errors: %0d", passCount, failCount, errorCount);
    if (errorCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
